//--- hw/merge_consts.svh
`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// ========================================
// Merger sizing

// Number of request clients
`define MERGE_CLIENTS 4

// Payload width of one client word
`define MERGE_DATA_W 16

// Entries in the shared buffer
// Also the number of credits the producer starts with
// Must be a power of two so the pointers wrap on their own
`define MERGE_BUF_DEPTH 8

`endif

//--- hw/merge_pkg.sv
`default_nettype none

`include "merge_consts.svh"

package merge_pkg;

    // ========================================
    // Shared vector types

    // One client payload word
    typedef logic [`MERGE_DATA_W-1:0] data_t;

    // Client number carried with each buffered word
    typedef logic [$clog2(`MERGE_CLIENTS)-1:0] cid_t;

    // Credit count, has to reach the full buffer depth
    typedef logic [$clog2(`MERGE_BUF_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire

//--- hw/merge_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// Producer to buffer, with the credit return path
interface push_if import merge_pkg::*; ();
    logic  push;
    data_t push_data;
    cid_t  push_cid;
    // One pulse per freed buffer entry
    logic  credit;

    modport producer (output push, output push_data, output push_cid, input credit);
    modport buffer (input push, input push_data, input push_cid, output credit);
endinterface

// Buffer head to consumer
interface pop_if import merge_pkg::*; ();
    logic  avail;
    data_t head_data;
    cid_t  head_cid;
    // Removes the head in the same cycle
    logic  take;

    modport buffer (output avail, output head_data, output head_cid, input take);
    modport consumer (input avail, input head_data, input head_cid, output take);
endinterface

`default_nettype wire

//--- hw/round_robin_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module round_robin_arbiter
#(
    parameter int CLIENTS = 4
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [CLIENTS-1:0] req,
    output logic [CLIENTS-1:0] gnt
);

    // Index width, at least one bit for a single client
    localparam int IDX_W = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;

    // ========================================
    // Priority masks from the previous winner

    // Bits strictly below the last winner
    logic [CLIENTS-1:0] mask_below;
    // Every bit except the last winner
    logic [CLIENTS-1:0] mask_other;

    logic [CLIENTS-1:0] req_below;
    logic [CLIENTS-1:0] req_other;
    logic               hit_below;
    logic               hit_other;
    logic [IDX_W-1:0]   idx_below;
    logic [IDX_W-1:0]   idx_other;

    logic               win_vld;
    logic [IDX_W-1:0]   winner;
    logic [CLIENTS-1:0] win_onehot;

    // Highest set bit of a vector, returned as {found, index}
    function automatic logic [IDX_W:0] find_high(input logic [CLIENTS-1:0] vec);
        logic             found;
        logic [IDX_W-1:0] idx;
        found = 1'b0;
        idx = '0;
        // Later hits overwrite earlier ones, so the top bit wins
        for (int i = 0; i < CLIENTS; i++)
        begin
            if (vec[i])
            begin
                found = 1'b1;
                idx = IDX_W'(i);
            end
        end
        return {found, idx};
    endfunction

    assign req_below = req & mask_below;
    assign req_other = req & mask_other;

    assign {hit_below, idx_below} = find_high(req_below);
    assign {hit_other, idx_other} = find_high(req_other);

    // Below the last winner first, then wrap to the top
    assign win_vld = hit_below | hit_other;
    assign winner = hit_below ? idx_below : idx_other;
    assign win_onehot = CLIENTS'(1) << winner;

    // ========================================
    // Registered state

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            // No history, so the highest requester wins first
            mask_below <= '0;
            mask_other <= '1;
            gnt <= '0;
        end
        else
        begin
            if (win_vld)
            begin
                mask_below <= win_onehot - CLIENTS'(1);
                mask_other <= ~win_onehot;
                gnt <= win_onehot;
            end
            else
            begin
                // Idle cycle lets the last winner back in
                mask_other <= '1;
                gnt <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/request_producer.sv
`timescale 1ns/100ps
`default_nettype none

`include "merge_consts.svh"

module request_producer
    import merge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`MERGE_CLIENTS-1:0] in_valid,
    input  data_t                     in_data [`MERGE_CLIENTS],
    output logic [`MERGE_CLIENTS-1:0] in_ready,
    push_if.producer                  push_bus
);

    logic [`MERGE_CLIENTS-1:0] req;
    logic [`MERGE_CLIENTS-1:0] gnt;
    credit_t                   credit_cnt;
    credit_t                   push_pending;
    logic                      can_req;
    data_t                     sel_data;
    cid_t                      sel_cid;

    // ========================================
    // Request gating

    // A push in this cycle has not left the counter yet
    assign push_pending = credit_t'(push_bus.push);
    // Room for one more word after the one in flight
    assign can_req = (credit_cnt > push_pending);

    // Granted client is dropped for one cycle
    // Its word is already taken
    assign req = can_req ? (in_valid & ~gnt) : '0;

    round_robin_arbiter #(
        .CLIENTS (`MERGE_CLIENTS)
    ) u_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .gnt   (gnt)
    );

    // ========================================
    // Data select and grant encode

    always_comb
    begin
        sel_data = '0;
        sel_cid = '0;
        // Grant is one-hot, so at most one term contributes
        for (int i = 0; i < `MERGE_CLIENTS; i++)
        begin
            if (gnt[i])
            begin
                sel_data = sel_data | in_data[i];
                sel_cid = cid_t'(i);
            end
        end
    end

    assign push_bus.push = |gnt;
    assign push_bus.push_data = sel_data;
    assign push_bus.push_cid = sel_cid;

    // Accept strobe back to the winning client
    assign in_ready = gnt;

    // ========================================
    // Credit counter

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credit_cnt <= credit_t'(`MERGE_BUF_DEPTH);
        end
        else
        begin
            case ({push_bus.push, push_bus.credit})
                2'b10: credit_cnt <= credit_cnt - credit_t'(1);
                2'b01: credit_cnt <= credit_cnt + credit_t'(1);
                // Both or neither leave the count unchanged
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/entry_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "merge_consts.svh"

module entry_buffer
    import merge_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    push_if.buffer push_bus,
    pop_if.buffer  pop_bus
);

    localparam int PTR_W = $clog2(`MERGE_BUF_DEPTH);

    // ========================================
    // Storage and pointers

    data_t            mem_data [`MERGE_BUF_DEPTH];
    cid_t             mem_cid [`MERGE_BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // Occupancy, same range as the credit count
    credit_t          count;

    // Write side, the producer never pushes into a full store
    always_ff @(posedge clk)
    begin
        if (push_bus.push)
        begin
            mem_data[wr_ptr] <= push_bus.push_data;
            mem_cid[wr_ptr] <= push_bus.push_cid;
        end
    end

    // Show-ahead head
    assign pop_bus.avail = (count != '0);
    assign pop_bus.head_data = mem_data[rd_ptr];
    assign pop_bus.head_cid = mem_cid[rd_ptr];

    // ========================================
    // Pointer, count and credit control

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            push_bus.credit <= 1'b0;
        end
        else
        begin
            if (push_bus.push)
                wr_ptr <= wr_ptr + PTR_W'(1);
            if (pop_bus.take)
                rd_ptr <= rd_ptr + PTR_W'(1);

            case ({push_bus.push, pop_bus.take})
                2'b10: count <= count + credit_t'(1);
                2'b01: count <= count - credit_t'(1);
                default: count <= count;
            endcase

            // One freed entry, one credit, a cycle later
            push_bus.credit <= pop_bus.take;
        end
    end

endmodule

`default_nettype wire

//--- hw/drain_consumer.sv
`timescale 1ns/100ps
`default_nettype none

module drain_consumer
    import merge_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    pop_if.consumer  pop_bus,
    output logic     out_valid,
    output data_t    out_data,
    output cid_t     out_cid,
    input  logic     out_ready
);

    // ========================================
    // Output register stage

    // Register is free, or its word leaves this cycle
    logic slot_free;

    assign slot_free = !out_valid || out_ready;
    assign pop_bus.take = pop_bus.avail && slot_free;

    // Valid flag
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            if (pop_bus.take)
                out_valid <= 1'b1;
            else if (out_ready)
                // Transfer done and nothing to refill with
                out_valid <= 1'b0;
        end
    end

    // Payload, held while out_ready is low
    always_ff @(posedge clk)
    begin
        if (pop_bus.take)
        begin
            out_data <= pop_bus.head_data;
            out_cid <= pop_bus.head_cid;
        end
    end

endmodule

`default_nettype wire

//--- hw/merge_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "merge_consts.svh"

module merge_top
    import merge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`MERGE_CLIENTS-1:0] in_valid,
    input  data_t                     in_data [`MERGE_CLIENTS],
    output logic [`MERGE_CLIENTS-1:0] in_ready,
    output logic                      out_valid,
    output data_t                     out_data,
    output cid_t                      out_cid,
    input  logic                      out_ready
);

    // ========================================
    // Internal links

    push_if push_bus ();
    pop_if  pop_bus ();

    // Arbitration and credit accounting
    request_producer u_producer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (in_ready),
        .push_bus (push_bus.producer)
    );

    // Shared tagged entry store
    entry_buffer u_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .push_bus (push_bus.buffer),
        .pop_bus  (pop_bus.buffer)
    );

    // Output stage toward the sink
    drain_consumer u_consumer (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop_bus   (pop_bus.consumer),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_cid   (out_cid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- verification/merge_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "merge_consts.svh"

module merge_tb
    import merge_pkg::*;
();

    localparam int N = `MERGE_CLIENTS;
    // Words sent over all tests set the watchdog limit
    localparam int TOTAL_WORDS = 4 * 24 + 4 * 8 + 16 + 4 * 8 + 3;
    localparam int LIMIT_CYC = TOTAL_WORDS * 20 + 500;
    localparam int SOLO = 2;
    // out_ready modes
    localparam int R_LOW = 0;
    localparam int R_HIGH = 1;
    localparam int R_RAND = 2;

    logic           clk;
    logic           rst_n;
    logic [N-1:0]   in_valid;
    data_t          in_data [N];
    logic [N-1:0]   in_ready;
    logic           out_valid;
    data_t          out_data;
    cid_t           out_cid;
    logic           out_ready;

    // ========================================
    // Bookkeeping

    data_t sent_q [N][$];
    int    left [N];
    int    n_sent = 0;
    int    n_recv = 0;
    int    errors = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    cyc = 0;
    int    rdy_mode = R_LOW;
    logic  gaps = 1'b0;
    logic  rr_chk = 1'b0;
    logic  single_chk = 1'b0;
    logic  lat_chk = 1'b0;
    logic  have_prev = 1'b0;
    cid_t  prev_cid;

    merge_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_cid   (out_cid),
        .out_ready (out_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // ========================================
    // Client drivers and sink back-pressure

    initial
    begin : drive_inputs
        logic acc;
        void'($urandom(32'h5942));
        forever
        begin
            @(posedge clk);
            for (int i = 0; i < N; i++)
            begin
                acc = in_valid[i] && in_ready[i];
                if (acc)
                begin
                    sent_q[i].push_back(in_data[i]);
                    left[i] = left[i] - 1;
                    n_sent++;
                end
                // Hold valid and data until accepted
                if (!in_valid[i] || acc)
                begin
                    in_valid[i] <= (left[i] > 0) && (!gaps || ($urandom % 2 == 1));
                    in_data[i] <= data_t'($urandom);
                end
            end
            // Sink side back-pressure
            out_ready <= (rdy_mode == R_RAND) ? ($urandom % 2 == 1)
                                              : (rdy_mode == R_HIGH);
        end
    end

    // ========================================
    // Scoreboard on output transfers

    always @(posedge clk)
    begin : score
        data_t exp;
        if (rst_n && out_valid && out_ready)
        begin
            if (sent_q[out_cid].size() == 0)
            begin
                errors++;
                $display("ERROR: output word for client %0d with nothing outstanding", out_cid);
            end
            else
            begin
                exp = sent_q[out_cid].pop_front();
                assert (out_data == exp)
                else
                begin
                    errors++;
                    $display("ERROR: out_data expected %h got %h", exp, out_data);
                end
            end
            // Downward rotation 3 2 1 0
            if (rr_chk && have_prev)
            begin
                assert (out_cid == cid_t'(prev_cid - 1'b1))
                else
                begin
                    errors++;
                    $display("ERROR: out_cid expected %h got %h", cid_t'(prev_cid - 1'b1), out_cid);
                end
            end
            prev_cid = out_cid;
            have_prev = 1'b1;
            n_recv++;
        end
    end

    // ========================================
    // Protocol checks

    // Reset cycles and the first cycle after release
    assert property (@(posedge clk) (cyc >= 1 && cyc <= 4) |-> (!out_valid && in_ready == '0))
    else
    begin
        errors++;
        $display("ERROR: out_valid/in_ready expected 0/0 got %h/%h",
                 $sampled(out_valid), $sampled(in_ready));
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_cid)))
    else
    begin
        errors++;
        $display("Output word changed or dropped while out_ready was low");
    end

    assert property (@(posedge clk) (single_chk && in_ready[SOLO]) |=> !in_ready[SOLO])
    else
    begin
        errors++;
        $display("Single client saw in_ready in two consecutive cycles");
    end

    assert property (@(posedge clk) single_chk |-> (in_ready & ~(N'(1) << SOLO)) == '0)
    else
    begin
        errors++;
        $display("ERROR: in_ready expected %h got %h", N'(0), $sampled(in_ready));
    end

    // Accept in cycle a and output in cycle a+2 exactly
    assert property (@(posedge clk)
        (lat_chk && in_ready[1]) |=> !out_valid ##1 (out_valid && out_cid == cid_t'(1)))
    else
    begin
        errors++;
        $display("Output word did not appear exactly two cycles after in_ready");
    end

    // ========================================
    // Test sequencing

    function automatic logic busy();
        logic b;
        b = (in_valid != '0) || out_valid;
        for (int i = 0; i < N; i++)
            b = b || (sent_q[i].size() != 0) || (left[i] != 0);
        return b;
    endfunction

    task automatic load_quota(input int words, input logic [N-1:0] which);
        for (int i = 0; i < N; i++)
            left[i] = which[i] ? words : 0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy())
            @(negedge clk);
        repeat (3) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int err_before);
        assert (n_recv == n_sent)
        else
        begin
            errors++;
            $display("ERROR: n_recv expected %h got %h", n_sent, n_recv);
        end
        if (errors == err_before)
        begin
            n_pass++;
            $display("Test %s: PASS", name);
        end
        else
        begin
            n_fail++;
            $display("Test %s: FAIL with %0d errors", name, errors - err_before);
        end
    endtask

    // Hang guard
    initial
    begin
        #(LIMIT_CYC * 100);
        $display("Run stopped by watchdog, the design stopped moving words");
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin : main
        int e0;
        int base;
        int mid;
        rst_n = 1'b0;
        in_valid = '0;
        out_ready = 1'b0;
        for (int i = 0; i < N; i++)
        begin
            in_data[i] = '0;
            left[i] = 0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);
        end_test("1 reset state", 0);

        e0 = errors;
        gaps = 1'b1;
        rdy_mode = R_RAND;
        load_quota(24, '1);
        wait_idle();
        gaps = 1'b0;
        end_test("2 data integrity", e0);

        e0 = errors;
        rdy_mode = R_HIGH;
        have_prev = 1'b0;
        rr_chk = 1'b1;
        load_quota(8, '1);
        wait_idle();
        rr_chk = 1'b0;
        end_test("3 round-robin order", e0);

        e0 = errors;
        single_chk = 1'b1;
        load_quota(16, N'(1) << SOLO);
        wait_idle();
        single_chk = 1'b0;
        end_test("4 single client", e0);

        // Stall the sink and let credits run out
        e0 = errors;
        rdy_mode = R_LOW;
        base = n_sent;
        load_quota(8, '1);
        repeat (40) @(negedge clk);
        mid = n_sent - base;
        repeat (10) @(negedge clk);
        assert (mid == `MERGE_BUF_DEPTH + 1 && n_sent - base == mid)
        else
        begin
            errors++;
            $display("ERROR: accepted expected %h got %h", `MERGE_BUF_DEPTH + 1, n_sent - base);
        end
        rdy_mode = R_HIGH;
        wait_idle();
        end_test("5 back-pressure", e0);

        e0 = errors;
        lat_chk = 1'b1;
        repeat (3)
        begin
            load_quota(1, N'(2));
            wait_idle();
        end
        lat_chk = 1'b0;
        end_test("6 latency", e0);

        $display("Tests passed: %0d, failed: %0d, errors: %0d", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/merge_pkg.sv
hw/merge_ifs.sv
hw/round_robin_arbiter.sv
hw/request_producer.sv
hw/entry_buffer.sv
hw/drain_consumer.sv
hw/merge_top.sv
verification/merge_tb.sv
